//--- tb.f
+incdir+rtl
rtl/mdom_serial_pkg.sv
rtl/spi_task_regs.sv
rtl/spi_arbiter.sv
rtl/spi_shifter.sv
rtl/spi_pin_router.sv
rtl/mdom_serial_top.sv
sim/tb_mdom_serial.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_mdom_serial -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" sim.log; then
  exit 1
fi
exit 0

//--- sim/tb_mdom_serial.sv
//******************************
// testbench for the slow-control spi top
// table rows run one task each, then all three at once
// device models: adc0, dac group 1, monitor 1
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "mdom_serial_consts.svh"

module tb_mdom_serial import mdom_serial_pkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int N_ROWS = 6;
  // arbitration phase counts as three more rows
  localparam int WATCH_CYCLES = (N_ROWS + 3) * (32 * 2 * `SCLK_HALF + 20) * 3;
  // register slots of one peripheral
  localparam int SL_SEL = 0;
  localparam int SL_TASK = 1;
  localparam int SL_WR_HI = 2;
  localparam int SL_WR_LO = 3;
  localparam int SL_RD_HI = 4;
  localparam int SL_RD_LO = 5;

  logic                   lclk;
  logic                   lclk_rst;
  logic                   reg_wr;
  logic [`REG_ADDR_W-1:0] reg_addr;
  reg_data_t              reg_wdata;
  reg_data_t              reg_rdata;
  logic [5:0]             adc_sen;
  logic                   adc_sclk;
  logic                   adc_sdata;
  logic                   adc_sdout = 1'b0;
  logic [2:0]             dac_sclk;
  logic [2:0]             dac_din;
  logic [8:0]             dac_nsync;
  logic [1:0]             mon_csn;
  logic [1:0]             mon_sclk;
  logic [1:0]             mon_sdi;
  // monitor 0 answers all ones, a wrong miso pick shows up
  logic [1:0]             mon_sdo = 2'b01;

  // stimulus table
  string      row_name [N_ROWS];
  client_t    row_client [N_ROWS];
  logic [5:0] row_sel [N_ROWS];
  spi_word_t  row_wr [N_ROWS];
  spi_word_t  row_pat [N_ROWS];
  spi_word_t  row_exp_cap [N_ROWS];
  int         row_exp_bits [N_ROWS];
  spi_word_t  row_exp_rd [N_ROWS];

  int seed = 18804;
  int n_checks = 0;
  int n_mismatch = 0;
  int n_other = 0;

  // device model state
  spi_word_t  adc_cap;
  spi_word_t  dac_cap;
  spi_word_t  mon_cap;
  int         adc_cnt;
  int         dac_cnt;
  int         mon_cnt;
  int         adc_out = 0;
  int         mon_out = 0;
  logic       adc_sclk_q = 1'b1;
  logic       dac_sclk_q = 1'b1;
  logic       mon_sclk_q = 1'b1;
  spi_word_t  adc_pat = '0;
  spi_word_t  mon_pat = '0;

  // select bookkeeping, low cycles per pin
  logic [5:0] adc_allow = '0;
  logic [8:0] dac_allow = '0;
  logic [1:0] mon_allow = '0;
  int         adc_low [6];
  int         dac_low [9];
  int         mon_low [2];
  int         adc_low0 [6];
  int         dac_low0 [9];
  int         mon_low0 [2];
  int         cnt0_adc;
  int         cnt0_dac;
  int         cnt0_mon;

  mdom_serial_top uut (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_reg_wr(reg_wr), .i_reg_addr(reg_addr), .i_reg_wdata(reg_wdata),
    .o_reg_rdata(reg_rdata),
    .o_adc_sen(adc_sen), .o_adc_sclk(adc_sclk), .o_adc_sdata(adc_sdata),
    .i_adc_sdout(adc_sdout),
    .o_dac_sclk(dac_sclk), .o_dac_din(dac_din), .o_dac_nsync(dac_nsync),
    .o_mon_csn(mon_csn), .o_mon_sclk(mon_sclk), .o_mon_sdi(mon_sdi),
    .i_mon_sdo(mon_sdo)
  );

  always #(CLK_PERIOD / 2) lclk = ~lclk;

  // adc0 model, mosi in on rising sclk, miso out on falling sclk
  always @(negedge lclk) begin
    if (lclk_rst) begin
      adc_cnt = 0;
      adc_cap = '0;
    end else if (!adc_sen[0]) begin
      if (adc_sclk && !adc_sclk_q) begin
        adc_cap = {adc_cap[30:0], adc_sdata};
        adc_cnt = adc_cnt + 1;
      end
      if (!adc_sclk && adc_sclk_q) begin
        adc_sdout = (adc_out < `ADC_NBITS) ? adc_pat[`ADC_NBITS - 1 - adc_out] : 1'b0;
        adc_out = adc_out + 1;
      end
    end else begin
      adc_out = 0;
    end
    adc_sclk_q = adc_sclk;
  end

  // dac group 1, any of its three chips
  always @(negedge lclk) begin
    if (lclk_rst) begin
      dac_cnt = 0;
      dac_cap = '0;
    end else if (!(&dac_nsync[5:3]) && dac_sclk[1] && !dac_sclk_q) begin
      dac_cap = {dac_cap[30:0], dac_din[1]};
      dac_cnt = dac_cnt + 1;
    end
    dac_sclk_q = dac_sclk[1];
  end

  // monitor adc 1
  always @(negedge lclk) begin
    if (lclk_rst) begin
      mon_cnt = 0;
      mon_cap = '0;
    end else if (!mon_csn[1]) begin
      if (mon_sclk[1] && !mon_sclk_q) begin
        mon_cap = {mon_cap[30:0], mon_sdi[1]};
        mon_cnt = mon_cnt + 1;
      end
      if (!mon_sclk[1] && mon_sclk_q) begin
        mon_sdo[1] = (mon_out < `MON_NBITS) ? mon_pat[`MON_NBITS - 1 - mon_out] : 1'b0;
        mon_out = mon_out + 1;
      end
    end else begin
      mon_out = 0;
    end
    mon_sclk_q = mon_sclk[1];
  end

  // selects only where allowed and one client at a time
  // idle buses stay quiet
  always @(negedge lclk) begin
    if (lclk_rst) begin
      foreach (adc_low[i]) adc_low[i] = 0;
      foreach (dac_low[i]) dac_low[i] = 0;
      foreach (mon_low[i]) mon_low[i] = 0;
    end else begin
      assert ((~adc_sen & ~adc_allow) == '0) else begin
        n_other = n_other + 1;
        $display("ERROR: adc select low on a chip that is not selected at %0t", $time);
      end
      assert ((~dac_nsync & ~dac_allow) == '0) else begin
        n_other = n_other + 1;
        $display("ERROR: dac sync low on a chip that is not selected at %0t", $time);
      end
      assert ((~mon_csn & ~mon_allow) == '0) else begin
        n_other = n_other + 1;
        $display("ERROR: monitor select low on a chip that is not selected at %0t", $time);
      end
      assert (int'(~&adc_sen) + int'(~&dac_nsync) + int'(~&mon_csn) <= 1) else begin
        n_other = n_other + 1;
        $display("ERROR: selects of two peripherals low at once at %0t", $time);
      end
      assert (!(&adc_sen) || (adc_sclk && !adc_sdata)) else begin
        n_other = n_other + 1;
        $display("ERROR: adc bus not idle with no chip selected at %0t", $time);
      end
      for (int g = 0; g < 3; g++) begin
        assert (!(&dac_nsync[3*g +: 3]) || (dac_sclk[g] && !dac_din[g])) else begin
          n_other = n_other + 1;
          $display("ERROR: dac group %0d not idle with no chip selected at %0t", g, $time);
        end
      end
      for (int m = 0; m < 2; m++) begin
        assert (!mon_csn[m] || (mon_sclk[m] && !mon_sdi[m])) else begin
          n_other = n_other + 1;
          $display("ERROR: monitor %0d not idle while deselected at %0t", m, $time);
        end
      end
      for (int i = 0; i < 6; i++) if (!adc_sen[i]) adc_low[i] = adc_low[i] + 1;
      for (int i = 0; i < 9; i++) if (!dac_nsync[i]) dac_low[i] = dac_low[i] + 1;
      for (int i = 0; i < 2; i++) if (!mon_csn[i]) mon_low[i] = mon_low[i] + 1;
    end
  end

  function automatic int nbits_of(input client_t c);
    case (c)
      CLIENT_ADC: return `ADC_NBITS;
      CLIENT_DAC: return `DAC_NBITS;
      default:    return `MON_NBITS;
    endcase
  endfunction

  function automatic spi_word_t low_mask(input int bits);
    return spi_word_t'((64'd1 << bits) - 64'd1);
  endfunction

  function automatic logic [`REG_ADDR_W-1:0] addr_of(input client_t c, input int slot);
    logic [6*`REG_ADDR_W-1:0] map;
    case (c)
      CLIENT_ADC: map = {`ADC_A_SEL, `ADC_A_TASK, `ADC_A_WR_HI,
                         `ADC_A_WR_LO, `ADC_A_RD_HI, `ADC_A_RD_LO};
      // write-only dac, read slots show the write word
      CLIENT_DAC: map = {`DAC_A_SEL, `DAC_A_TASK, `DAC_A_WR_HI,
                         `DAC_A_WR_LO, `DAC_A_WR_HI, `DAC_A_WR_LO};
      default:    map = {`MON_A_SEL, `MON_A_TASK, `MON_A_WR_HI,
                         `MON_A_WR_LO, `MON_A_RD_HI, `MON_A_RD_LO};
    endcase
    return map[(5 - slot) * `REG_ADDR_W +: `REG_ADDR_W];
  endfunction

  // sync lines from {chip[2:0], group[2:0]}
  function automatic logic [8:0] nsync_mask(input logic [5:0] sel);
    logic [8:0] m;
    m = '0;
    for (int g = 0; g < 3; g++) begin
      for (int c = 0; c < 3; c++) begin
        if (sel[g] && sel[3+c]) m[3*g+c] = 1'b1;
      end
    end
    return m;
  endfunction

  function automatic int model_cnt(input client_t c);
    case (c)
      CLIENT_ADC: return adc_cnt - cnt0_adc;
      CLIENT_DAC: return dac_cnt - cnt0_dac;
      default:    return mon_cnt - cnt0_mon;
    endcase
  endfunction

  function automatic spi_word_t model_cap(input client_t c);
    case (c)
      CLIENT_ADC: return adc_cap;
      CLIENT_DAC: return dac_cap;
      default:    return mon_cap;
    endcase
  endfunction

  task automatic add_row(input int r, input string name, input client_t c,
                         input logic [5:0] sel, input spi_word_t wr);
    int bits;
    bits = nbits_of(c);
    row_name[r] = name;
    row_client[r] = c;
    row_sel[r] = sel;
    row_wr[r] = wr;
    row_pat[r] = $random(seed);
    row_exp_cap[r] = wr & low_mask(bits);
    row_exp_bits[r] = bits;
    row_exp_rd[r] = (c == CLIENT_DAC) ? (wr & low_mask(bits)) : (row_pat[r] & low_mask(bits));
  endtask

  task automatic check_value(input string name, input string what,
                             input spi_word_t exp, input spi_word_t act);
    n_checks = n_checks + 1;
    assert (act === exp) else begin
      n_mismatch = n_mismatch + 1;
      $display("MISMATCH %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // called on a falling edge, returns on the next one
  task automatic drive_write(input logic [`REG_ADDR_W-1:0] addr, input reg_data_t data);
    reg_wr = 1'b1;
    reg_addr = addr;
    reg_wdata = data;
    @(negedge lclk);
    reg_wr = 1'b0;
  endtask

  task automatic read_reg(input logic [`REG_ADDR_W-1:0] addr, output reg_data_t data);
    reg_wr = 1'b0;
    reg_addr = addr;
    #(CLK_PERIOD / 4);
    data = reg_rdata;
    @(negedge lclk);
  endtask

  task automatic wait_idle(input client_t c);
    reg_data_t v;
    do begin
      read_reg(addr_of(c, SL_TASK), v);
    end while (v[0]);
  endtask

  task automatic wait_all_idle();
    reg_data_t va;
    reg_data_t vd;
    reg_data_t vm;
    do begin
      read_reg(addr_of(CLIENT_ADC, SL_TASK), va);
      read_reg(addr_of(CLIENT_DAC, SL_TASK), vd);
      read_reg(addr_of(CLIENT_MON, SL_TASK), vm);
    end while (va[0] || vd[0] || vm[0]);
  endtask

  task automatic set_allow(input client_t c, input logic [5:0] sel);
    case (c)
      CLIENT_ADC: adc_allow = sel;
      CLIENT_DAC: dac_allow = nsync_mask(sel);
      default:    mon_allow = 2'b01 << sel[0];
    endcase
  endtask

  task automatic take_snapshot();
    cnt0_adc = adc_cnt;
    cnt0_dac = dac_cnt;
    cnt0_mon = mon_cnt;
    adc_low0 = adc_low;
    dac_low0 = dac_low;
    mon_low0 = mon_low;
  endtask

  task automatic setup_client(input int r);
    client_t c;
    c = row_client[r];
    if (c == CLIENT_ADC) adc_pat = row_pat[r];
    if (c == CLIENT_MON) mon_pat = row_pat[r];
    set_allow(c, row_sel[r]);
    drive_write(addr_of(c, SL_SEL), reg_data_t'(row_sel[r]));
    drive_write(addr_of(c, SL_WR_HI), row_wr[r][31:16]);
    drive_write(addr_of(c, SL_WR_LO), row_wr[r][15:0]);
  endtask

  task automatic check_transfer(input string name, input int r);
    client_t   c;
    reg_data_t hi;
    reg_data_t lo;
    c = row_client[r];
    check_value(name, "bit count", spi_word_t'(row_exp_bits[r]), spi_word_t'(model_cnt(c)));
    check_value(name, "captured word", row_exp_cap[r],
                model_cap(c) & low_mask(row_exp_bits[r]));
    read_reg(addr_of(c, SL_RD_HI), hi);
    read_reg(addr_of(c, SL_RD_LO), lo);
    check_value(name, "read data", row_exp_rd[r], {hi, lo});
  endtask

  // every allowed select went low at some point
  task automatic check_selects(input string name);
    logic [5:0] adc_seen;
    logic [8:0] dac_seen;
    logic [1:0] mon_seen;
    for (int i = 0; i < 6; i++) adc_seen[i] = (adc_low[i] != adc_low0[i]);
    for (int i = 0; i < 9; i++) dac_seen[i] = (dac_low[i] != dac_low0[i]);
    for (int i = 0; i < 2; i++) mon_seen[i] = (mon_low[i] != mon_low0[i]);
    check_value(name, "adc selects", spi_word_t'(adc_allow), spi_word_t'(adc_seen));
    check_value(name, "dac selects", spi_word_t'(dac_allow), spi_word_t'(dac_seen));
    check_value(name, "monitor selects", spi_word_t'(mon_allow), spi_word_t'(mon_seen));
  endtask

  task automatic run_row(input int r);
    reg_data_t v;
    client_t   c;
    c = row_client[r];
    adc_allow = '0;
    dac_allow = '0;
    mon_allow = '0;
    take_snapshot();
    setup_client(r);
    drive_write(addr_of(c, SL_TASK), 16'h0001);
    // these must bounce off the busy peripheral
    drive_write(addr_of(c, SL_WR_LO), ~row_wr[r][15:0]);
    drive_write(addr_of(c, SL_SEL), reg_data_t'(~row_sel[r]));
    read_reg(addr_of(c, SL_TASK), v);
    check_value(row_name[r], "busy after task write", 32'd1, spi_word_t'(v));
    wait_idle(c);
    check_transfer(row_name[r], r);
    check_selects(row_name[r]);
  endtask

  // one task per client in back-to-back cycles
  task automatic run_arbitration();
    adc_allow = '0;
    dac_allow = '0;
    mon_allow = '0;
    take_snapshot();
    setup_client(0);
    setup_client(2);
    setup_client(4);
    drive_write(addr_of(CLIENT_ADC, SL_TASK), 16'h0001);
    drive_write(addr_of(CLIENT_DAC, SL_TASK), 16'h0001);
    drive_write(addr_of(CLIENT_MON, SL_TASK), 16'h0001);
    wait_all_idle();
    check_transfer("arbitration_adc", 0);
    check_transfer("arbitration_dac", 2);
    check_transfer("arbitration_mon", 4);
    check_selects("arbitration");
  endtask

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("ERROR: timeout after %0d cycles, a task did not finish", WATCH_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    reg_data_t v;
    lclk = 1'b0;
    lclk_rst = 1'b1;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    add_row(0, "adc_one", CLIENT_ADC, 6'h01, 32'h12a5_c35a);
    add_row(1, "adc_three", CLIENT_ADC, 6'h0d, $random(seed));
    // group 1 chip 0, then group 1 chip 2
    add_row(2, "dac_g1_c0", CLIENT_DAC, 6'h0a, 32'h3f00_81c7);
    add_row(3, "dac_g1_c2", CLIENT_DAC, 6'h22, $random(seed));
    add_row(4, "mon_one", CLIENT_MON, 6'h01, 32'hfffb_6d29);
    add_row(5, "mon_rand", CLIENT_MON, 6'h01, $random(seed));
    repeat (2) @(negedge lclk);
    lclk_rst = 1'b0;
    // nothing pending out of reset
    read_reg(addr_of(CLIENT_ADC, SL_TASK), v);
    check_value("reset", "adc busy", 32'd0, spi_word_t'(v));
    read_reg(addr_of(CLIENT_DAC, SL_TASK), v);
    check_value("reset", "dac busy", 32'd0, spi_word_t'(v));
    read_reg(addr_of(CLIENT_MON, SL_TASK), v);
    check_value("reset", "monitor busy", 32'd0, spi_word_t'(v));
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    run_arbitration();
    repeat (2) @(negedge lclk);
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/mdom_serial_top.sv
//******************************
// slow-control spi top
// three register blocks share one engine
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "mdom_serial_consts.svh"

module mdom_serial_top import mdom_serial_pkg::*; (
  input  logic                   lclk,
  input  logic                   lclk_rst,
  input  logic                   i_reg_wr,
  input  logic [`REG_ADDR_W-1:0] i_reg_addr,
  input  reg_data_t              i_reg_wdata,
  output reg_data_t              o_reg_rdata,
  output logic [5:0]             o_adc_sen,
  output logic                   o_adc_sclk,
  output logic                   o_adc_sdata,
  input  logic                   i_adc_sdout,
  output logic [2:0]             o_dac_sclk,
  output logic [2:0]             o_dac_din,
  output logic [8:0]             o_dac_nsync,
  output logic [1:0]             o_mon_csn,
  output logic [1:0]             o_mon_sclk,
  output logic [1:0]             o_mon_sdi,
  input  logic [1:0]             i_mon_sdo
);

  logic [2:0]            req;
  logic [2:0]            ack;
  adc_word_t             adc_tx;
  dac_word_t             dac_tx;
  mon_word_t             mon_tx;
  logic [5:0]            adc_sel;
  logic [5:0]            dac_sel;
  logic                  mon_sel;
  reg_data_t             adc_chain;
  reg_data_t             dac_chain;
  logic                  start;
  spi_word_t             word;
  logic [`SPI_CNT_W-1:0] nbits;
  client_t               grant;
  logic                  busy;
  logic                  done;
  spi_word_t             rx_word;
  logic                  sclk;
  logic                  mosi;
  logic                  miso;

  // read chain head, unmapped reads 0
  spi_task_regs #(
    .T_WORD(adc_word_t), .SEL_W(6),
    .A_SEL(`ADC_A_SEL), .A_TASK(`ADC_A_TASK),
    .A_WR_HI(`ADC_A_WR_HI), .A_WR_LO(`ADC_A_WR_LO),
    .A_RD_HI(`ADC_A_RD_HI), .A_RD_LO(`ADC_A_RD_LO)
  ) adc_regs (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata),
    .i_chain_rdata('0), .i_ack(ack[CLIENT_ADC]),
    .i_rx_word(rx_word[`ADC_NBITS-1:0]),
    .o_chain_rdata(adc_chain), .o_req(req[CLIENT_ADC]),
    .o_tx_word(adc_tx), .o_sel(adc_sel)
  );

  // dac is write only, read slots alias the write slots
  spi_task_regs #(
    .T_WORD(dac_word_t), .SEL_W(6),
    .A_SEL(`DAC_A_SEL), .A_TASK(`DAC_A_TASK),
    .A_WR_HI(`DAC_A_WR_HI), .A_WR_LO(`DAC_A_WR_LO),
    .A_RD_HI(`DAC_A_WR_HI), .A_RD_LO(`DAC_A_WR_LO)
  ) dac_regs (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata),
    .i_chain_rdata(adc_chain), .i_ack(ack[CLIENT_DAC]),
    .i_rx_word(rx_word[`DAC_NBITS-1:0]),
    .o_chain_rdata(dac_chain), .o_req(req[CLIENT_DAC]),
    .o_tx_word(dac_tx), .o_sel(dac_sel)
  );

  // chain tail drives the bus
  spi_task_regs #(
    .T_WORD(mon_word_t), .SEL_W(1),
    .A_SEL(`MON_A_SEL), .A_TASK(`MON_A_TASK),
    .A_WR_HI(`MON_A_WR_HI), .A_WR_LO(`MON_A_WR_LO),
    .A_RD_HI(`MON_A_RD_HI), .A_RD_LO(`MON_A_RD_LO)
  ) mon_regs (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_reg_wr(i_reg_wr), .i_reg_addr(i_reg_addr), .i_reg_wdata(i_reg_wdata),
    .i_chain_rdata(dac_chain), .i_ack(ack[CLIENT_MON]),
    .i_rx_word(rx_word[`MON_NBITS-1:0]),
    .o_chain_rdata(o_reg_rdata), .o_req(req[CLIENT_MON]),
    .o_tx_word(mon_tx), .o_sel(mon_sel)
  );

  spi_arbiter arbiter (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_req(req), .i_adc_word(adc_tx), .i_dac_word(dac_tx), .i_mon_word(mon_tx),
    .i_done(done),
    .o_start(start), .o_word(word), .o_nbits(nbits),
    .o_grant(grant), .o_busy(busy), .o_ack(ack)
  );

  spi_shifter shifter (
    .lclk(lclk), .lclk_rst(lclk_rst),
    .i_start(start), .i_word(word), .i_nbits(nbits), .i_miso(miso),
    .o_sclk(sclk), .o_mosi(mosi), .o_done(done), .o_rx_word(rx_word)
  );

  spi_pin_router router (
    .i_grant(grant), .i_busy(busy), .i_sclk(sclk), .i_mosi(mosi),
    .i_adc_sel(adc_sel), .i_dac_sel(dac_sel), .i_mon_sel(mon_sel),
    .i_adc_sdout(i_adc_sdout), .i_mon_sdo(i_mon_sdo),
    .o_adc_sen(o_adc_sen), .o_adc_sclk(o_adc_sclk), .o_adc_sdata(o_adc_sdata),
    .o_dac_sclk(o_dac_sclk), .o_dac_din(o_dac_din), .o_dac_nsync(o_dac_nsync),
    .o_mon_csn(o_mon_csn), .o_mon_sclk(o_mon_sclk), .o_mon_sdi(o_mon_sdi),
    .o_miso(miso)
  );

endmodule

`default_nettype wire

//--- rtl/spi_pin_router.sv
//******************************
// engine lines to device pins
// selects low only for the granted client
// idle pins: sclk high, data low
//******************************
`timescale 1ns/1ps
`default_nettype none

module spi_pin_router import mdom_serial_pkg::*; (
  input  client_t    i_grant,
  input  logic       i_busy,
  input  logic       i_sclk,
  input  logic       i_mosi,
  input  logic [5:0] i_adc_sel,
  input  logic [5:0] i_dac_sel,
  input  logic       i_mon_sel,
  input  logic       i_adc_sdout,
  input  logic [1:0] i_mon_sdo,
  output logic [5:0] o_adc_sen,
  output logic       o_adc_sclk,
  output logic       o_adc_sdata,
  output logic [2:0] o_dac_sclk,
  output logic [2:0] o_dac_din,
  output logic [8:0] o_dac_nsync,
  output logic [1:0] o_mon_csn,
  output logic [1:0] o_mon_sclk,
  output logic [1:0] o_mon_sdi,
  output logic       o_miso
);

  logic adc_on;
  logic dac_on;
  logic mon_on;
  logic adc_bus;

  assign adc_on = i_busy && (i_grant == CLIENT_ADC);
  assign dac_on = i_busy && (i_grant == CLIENT_DAC);
  assign mon_on = i_busy && (i_grant == CLIENT_MON);

  // six adcs on one bus, sen picks the chips
  assign adc_bus = adc_on && (|i_adc_sel);
  assign o_adc_sen = adc_on ? ~i_adc_sel : 6'h3f;
  assign o_adc_sclk = adc_bus ? i_sclk : 1'b1;
  assign o_adc_sdata = adc_bus ? i_mosi : 1'b0;

  always_comb begin
    // dac group g in sel[2:0], chip c in sel[5:3]
    for (int g = 0; g < 3; g++) begin
      o_dac_sclk[g] = (dac_on && i_dac_sel[g]) ? i_sclk : 1'b1;
      o_dac_din[g] = (dac_on && i_dac_sel[g]) ? i_mosi : 1'b0;
      for (int c = 0; c < 3; c++) begin
        o_dac_nsync[3*g+c] = !(dac_on && i_dac_sel[g] && i_dac_sel[3+c]);
      end
    end
    // one monitor at a time, own sclk and sdi
    for (int m = 0; m < 2; m++) begin
      o_mon_csn[m] = !(mon_on && (int'(i_mon_sel) == m));
      o_mon_sclk[m] = (mon_on && (int'(i_mon_sel) == m)) ? i_sclk : 1'b1;
      o_mon_sdi[m] = (mon_on && (int'(i_mon_sel) == m)) ? i_mosi : 1'b0;
    end
  end

  always_comb begin
    case (i_grant)
      CLIENT_ADC: o_miso = i_adc_sdout;
      CLIENT_MON: o_miso = i_mon_sdo[i_mon_sel];
      // ad5668 has no data out
      default:    o_miso = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/spi_shifter.sv
//******************************
// shared spi shift engine
// sclk idles high, mosi on falling edge
// miso sampled on rising edge, msb first
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "mdom_serial_consts.svh"

module spi_shifter import mdom_serial_pkg::*; (
  input  logic                  lclk,
  input  logic                  lclk_rst,
  input  logic                  i_start,
  input  spi_word_t             i_word,
  input  logic [`SPI_CNT_W-1:0] i_nbits,
  input  logic                  i_miso,
  output logic                  o_sclk,
  output logic                  o_mosi,
  output logic                  o_done,
  output spi_word_t             o_rx_word
);

  localparam int HALF = `SCLK_HALF;
  localparam int DIV_W = $clog2(HALF + 1);

  logic                  active;
  logic [DIV_W-1:0]      div;
  logic [`SPI_CNT_W-1:0] bits_left;
  spi_word_t             tx_sr;
  spi_word_t             aligned;
  logic                  tick;
  logic                  rise;
  logic                  fall;
  logic                  load;

  // payload moved up so its first bit sits at the msb
  assign aligned = i_word << (`SPI_WORD_W - i_nbits);

  assign load = i_start && !active;
  // end of a half period
  assign tick = active && (div == DIV_W'(HALF - 1));
  assign rise = tick && !o_sclk;
  assign fall = tick && o_sclk && (bits_left != 1);

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      active <= 1'b0;
      div <= '0;
      bits_left <= '0;
      o_sclk <= 1'b1;
      o_mosi <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (load) begin
        // first falling edge right away
        active <= 1'b1;
        div <= '0;
        bits_left <= i_nbits;
        o_sclk <= 1'b0;
        o_mosi <= aligned[`SPI_WORD_W-1];
      end else if (active) begin
        if (tick) begin
          div <= '0;
        end else begin
          div <= div + 1'b1;
        end
        if (rise) begin
          o_sclk <= 1'b1;
        end else if (fall) begin
          o_sclk <= 1'b0;
          o_mosi <= tx_sr[`SPI_WORD_W-1];
          bits_left <= bits_left - 1'b1;
        end else if (tick) begin
          // high half of last bit over
          active <= 1'b0;
          o_done <= 1'b1;
          o_mosi <= 1'b0;
        end
      end
    end
  end

  // shift registers
  always_ff @(posedge lclk) begin
    if (load) begin
      tx_sr <= aligned << 1;
      o_rx_word <= '0;
    end else begin
      if (fall) begin
        tx_sr <= tx_sr << 1;
      end
      // received bits end up right-aligned
      if (rise) begin
        o_rx_word <= {o_rx_word[`SPI_WORD_W-2:0], i_miso};
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/spi_arbiter.sv
//******************************
// round-robin owner of the shared spi engine
// one transfer at a time, done becomes the ack
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "mdom_serial_consts.svh"

module spi_arbiter import mdom_serial_pkg::*; (
  input  logic                  lclk,
  input  logic                  lclk_rst,
  input  logic [2:0]            i_req,
  input  adc_word_t             i_adc_word,
  input  dac_word_t             i_dac_word,
  input  mon_word_t             i_mon_word,
  input  logic                  i_done,
  output logic                  o_start,
  output spi_word_t             o_word,
  output logic [`SPI_CNT_W-1:0] o_nbits,
  output client_t               o_grant,
  output logic                  o_busy,
  output logic [2:0]            o_ack
);

  localparam logic [`SPI_CNT_W-1:0] ADC_CNT = `ADC_NBITS;
  localparam logic [`SPI_CNT_W-1:0] DAC_CNT = `DAC_NBITS;
  localparam logic [`SPI_CNT_W-1:0] MON_CNT = `MON_NBITS;

  client_t pick;
  logic    found;

  // search starts one past the current grant
  always_comb begin
    int idx;
    pick = o_grant;
    found = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      idx = (int'(o_grant) + k) % 3;
      if (!found && i_req[idx]) begin
        pick = client_t'(idx);
        found = 1'b1;
      end
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_busy <= 1'b0;
      o_start <= 1'b0;
      // so the first search begins at the adc
      o_grant <= CLIENT_MON;
    end else begin
      o_start <= 1'b0;
      if (!o_busy && found) begin
        o_busy <= 1'b1;
        o_start <= 1'b1;
        o_grant <= pick;
      end else if (i_done) begin
        o_busy <= 1'b0;
      end
    end
  end

  // payloads stay put while busy, mux is enough
  always_comb begin
    case (o_grant)
      CLIENT_ADC: begin
        o_word = spi_word_t'(i_adc_word);
        o_nbits = ADC_CNT;
      end
      CLIENT_DAC: begin
        o_word = spi_word_t'(i_dac_word);
        o_nbits = DAC_CNT;
      end
      CLIENT_MON: begin
        o_word = spi_word_t'(i_mon_word);
        o_nbits = MON_CNT;
      end
      default: begin
        o_word = '0;
        o_nbits = '0;
      end
    endcase
  end

  // done routed back to the owner
  assign o_ack = i_done ? (3'b001 << o_grant) : 3'b000;

endmodule

`default_nettype wire

//--- rtl/spi_task_regs.sv
//******************************
// task registers of one spi peripheral
// select, write word, read word, request level
// read-back passes through as a chain
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "mdom_serial_consts.svh"

module spi_task_regs import mdom_serial_pkg::*; #(
  parameter type T_WORD = spi_word_t,
  parameter int SEL_W = 1,
  parameter logic [`REG_ADDR_W-1:0] A_SEL = '0,
  parameter logic [`REG_ADDR_W-1:0] A_TASK = '0,
  parameter logic [`REG_ADDR_W-1:0] A_WR_HI = '0,
  parameter logic [`REG_ADDR_W-1:0] A_WR_LO = '0,
  parameter logic [`REG_ADDR_W-1:0] A_RD_HI = '0,
  parameter logic [`REG_ADDR_W-1:0] A_RD_LO = '0
) (
  input  logic                   lclk,
  input  logic                   lclk_rst,
  input  logic                   i_reg_wr,
  input  logic [`REG_ADDR_W-1:0] i_reg_addr,
  input  reg_data_t              i_reg_wdata,
  input  reg_data_t              i_chain_rdata,
  input  logic                   i_ack,
  input  T_WORD                  i_rx_word,
  output reg_data_t              o_chain_rdata,
  output logic                   o_req,
  output T_WORD                  o_tx_word,
  output logic [SEL_W-1:0]       o_sel
);

  localparam int W = $bits(T_WORD);

  T_WORD tx_word;
  T_WORD rx_word;
  logic  wr_ok;

  // data and selects frozen while a task is pending
  assign wr_ok = i_reg_wr && !o_req;

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_req <= 1'b0;
      o_sel <= '0;
    end else begin
      // ack ends the task
      if (i_ack) begin
        o_req <= 1'b0;
      end else if (i_reg_wr && i_reg_addr == A_TASK && i_reg_wdata[0]) begin
        o_req <= 1'b1;
      end
      if (wr_ok && i_reg_addr == A_SEL) begin
        o_sel <= i_reg_wdata[SEL_W-1:0];
      end
    end
  end

  always_ff @(posedge lclk) begin
    // upper word bits start at bit 16
    if (wr_ok && i_reg_addr == A_WR_HI) begin
      tx_word[W-1:16] <= i_reg_wdata[W-17:0];
    end
    if (wr_ok && i_reg_addr == A_WR_LO) begin
      tx_word[15:0] <= i_reg_wdata;
    end
    // received word taken in the ack cycle
    if (i_ack) begin
      rx_word <= i_rx_word;
    end
  end

  assign o_tx_word = tx_word;

  // own address wins, otherwise pass upstream value
  // write slots decode before read slots, so a peripheral without
  // readback aliases its read slots onto its write slots
  always_comb begin
    if (i_reg_addr == A_TASK) begin
      o_chain_rdata = reg_data_t'(o_req);
    end else if (i_reg_addr == A_SEL) begin
      o_chain_rdata = reg_data_t'(o_sel);
    end else if (i_reg_addr == A_WR_HI) begin
      o_chain_rdata = reg_data_t'(tx_word[W-1:16]);
    end else if (i_reg_addr == A_WR_LO) begin
      o_chain_rdata = tx_word[15:0];
    end else if (i_reg_addr == A_RD_HI) begin
      o_chain_rdata = reg_data_t'(rx_word[W-1:16]);
    end else if (i_reg_addr == A_RD_LO) begin
      o_chain_rdata = rx_word[15:0];
    end else begin
      o_chain_rdata = i_chain_rdata;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mdom_serial_pkg.sv
//******************************
// payload and grant types for the spi block
// shared by rtl and testbench
//******************************
`default_nettype none

`include "mdom_serial_consts.svh"

package mdom_serial_pkg;

  // per-device payloads
  typedef logic [`ADC_NBITS-1:0] adc_word_t;
  typedef logic [`DAC_NBITS-1:0] dac_word_t;
  typedef logic [`MON_NBITS-1:0] mon_word_t;

  // shared engine word, widest payload
  typedef logic [`SPI_WORD_W-1:0] spi_word_t;

  // grant index, also the bit position in req/ack vectors
  typedef enum logic [1:0] {
    CLIENT_ADC = 2'd0,
    CLIENT_DAC = 2'd1,
    CLIENT_MON = 2'd2
  } client_t;

  // register bus data
  typedef logic [`REG_DATA_W-1:0] reg_data_t;

endpackage

`default_nettype wire

//--- rtl/mdom_serial_consts.svh
//******************************
// constants for the slow-control spi block
// register map, bit counts, sclk timing
// include where a width or address is needed
//******************************
`ifndef MDOM_SERIAL_CONSTS_SVH
`define MDOM_SERIAL_CONSTS_SVH

// engine word and bit-count field
`define SPI_WORD_W 32
`define SPI_CNT_W 6
// lclk cycles per sclk half period
`define SCLK_HALF 4

// bits per transfer
`define ADC_NBITS 24
`define DAC_NBITS 32
`define MON_NBITS 19

// adc3424 config port
`define ADC_A_SEL 12'hbdc
`define ADC_A_TASK 12'hbdb
`define ADC_A_WR_HI 12'hbda
`define ADC_A_WR_LO 12'hbd9
`define ADC_A_RD_HI 12'hbde
`define ADC_A_RD_LO 12'hbd8

// ad5668 groups, select is {chip[2:0], group[2:0]}
`define DAC_A_SEL 12'hbd7
`define DAC_A_TASK 12'hbd5
`define DAC_A_WR_HI 12'hbd4
`define DAC_A_WR_LO 12'hbd3

// ads8332 monitors
`define MON_A_SEL 12'hdf6
`define MON_A_TASK 12'heff
`define MON_A_WR_HI 12'hdf8
`define MON_A_WR_LO 12'hde4
`define MON_A_RD_HI 12'hdf7
`define MON_A_RD_LO 12'hde3

// register bus
`define REG_ADDR_W 12
`define REG_DATA_W 16

`endif
